// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
  import mips_isa_pkg::*;
(
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_e op,
  output word_t        result,
  output logic         zero
);

  word_t sum;
  word_t diff;
  logic  less;

  assign sum  = a + b;
  assign diff = a - b;
  assign less = ($signed(a) < $signed(b));

  always_comb
  begin
    case (op)
      alu_and:
        result = a & b;
      alu_or:
        result = a | b;
      alu_add:
        result = sum;
      alu_sub:
        result = diff;
      alu_slt:
        result = {31'b0, less};  // signed compare
      default:
        result = '0;
    endcase
  end

  assign zero = (result == '0);  // branch condition

endmodule

`default_nettype wire

// ==== build.f ====
mips_isa_pkg.sv
mips_pipe_pkg.sv
main_decoder.sv
reg_file.sv
hazard_unit.sv
alu.sv
mips_pipeline.sv
tb_mips.sv

// ==== hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  wire            clk,          // assertion sampling only
  input  wire            rst,
  input  wire reg_addr_t ex_rs,
  input  wire reg_addr_t ex_rt,
  input  wire reg_addr_t ex_dest_mem,  // EX/MEM destination
  input  wire reg_addr_t ex_dest_wb,   // MEM/WB destination
  input  wire reg_addr_t id_rs,
  input  wire reg_addr_t id_rt,
  input  wire            mem_reg_write,
  input  wire            wb_reg_write,
  input  wire            ex_mem_to_reg,
  output fwd_sel_e       fwd_a,
  output fwd_sel_e       fwd_b,
  output logic           stall
);

  // newest producer wins
  function automatic fwd_sel_e fwd_select(input reg_addr_t src);
    if (mem_reg_write && (ex_dest_mem != '0) && (ex_dest_mem == src))
      return fwd_mem;
    else if (wb_reg_write && (ex_dest_wb != '0) && (ex_dest_wb == src))
      return fwd_wb;
    else
      return fwd_none;
  endfunction

  always_comb
  begin
    fwd_a = fwd_select(ex_rs);
    fwd_b = fwd_select(ex_rt);
  end

  // load in EX feeding the instruction in ID
  assign stall = ex_mem_to_reg && ((ex_rt == id_rs) || (ex_rt == id_rt));

  // --------------------
  // checks
  // --------------------
  a_stall_single: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
    else $error("load-use stall held two cycles");

  a_no_fwd_r0: assert property (@(posedge clk) disable iff (rst)
    ((fwd_a == fwd_mem) |-> (ex_rs != '0)) and ((fwd_b == fwd_mem) |-> (ex_rt != '0)))
    else $error("forward from MEM selected for r0");

endmodule

`default_nettype wire

// ==== main_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_decoder
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  wire word_t instr,
  output ctrl_t      ctrl
);

  opcode_e opcode;
  funct_e  funct;

  assign opcode = opcode_e'(instr[op_msb -: 6]);
  assign funct  = funct_e'(instr[funct_msb:0]);

  always_comb
  begin
    ctrl = '0;  // unknown encodings fall through as a nop
    case (opcode)
      op_rtype:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = 1'b1;
        case (funct)
          fn_add, fn_addu: ctrl.alu_op = alu_add;
          fn_sub, fn_subu: ctrl.alu_op = alu_sub;
          fn_and:          ctrl.alu_op = alu_and;
          fn_or:           ctrl.alu_op = alu_or;
          fn_slt, fn_sltu: ctrl.alu_op = alu_slt;  // sltu runs the signed compare
          default:         ctrl = '0;
        endcase
      end
      op_lw:
      begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.sign_ext   = 1'b1;
        ctrl.alu_op     = alu_add;
      end
      op_sw:
      begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.sign_ext  = 1'b1;
        ctrl.alu_op    = alu_add;
      end
      op_beq, op_bne:
      begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = (opcode == op_bne);
        ctrl.sign_ext  = 1'b1;
        ctrl.alu_op    = alu_sub;  // compare via zero flag
      end
      op_addi, op_addiu:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.sign_ext  = 1'b1;
        ctrl.alu_op    = alu_add;
      end
      op_ori:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_or;  // zero extended imm
      end
      op_lui:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.shift16   = 1'b1;
        ctrl.alu_op    = alu_add;  // rs is r0
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // --------------------
  // instruction fields
  // --------------------
  localparam int op_msb    = 31;
  localparam int rs_lsb    = 21;
  localparam int rt_lsb    = 16;
  localparam int rd_lsb    = 11;
  localparam int funct_msb = 5;
  localparam int imm_width = 16;
  localparam int reg_count = 32;

  localparam word_t pc_step  = 32'd4;
  localparam word_t reset_pc = 32'h0000_0000;  // first fetch address

  // --------------------
  // opcodes and functs
  // --------------------
  typedef enum logic [5:0] {
    op_rtype = 6'b000000,
    op_beq   = 6'b000100,
    op_bne   = 6'b000101,
    op_addi  = 6'b001000,
    op_addiu = 6'b001001,
    op_ori   = 6'b001101,
    op_lui   = 6'b001111,
    op_lw    = 6'b100011,
    op_sw    = 6'b101011
  } opcode_e;

  typedef enum logic [5:0] {
    fn_add  = 6'b100000,
    fn_addu = 6'b100001,
    fn_sub  = 6'b100010,
    fn_subu = 6'b100011,
    fn_and  = 6'b100100,
    fn_or   = 6'b100101,
    fn_slt  = 6'b101010,
    fn_sltu = 6'b101011
  } funct_e;

  // alu control encodings
  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_e;

endpackage

`default_nettype wire

// ==== mips_pipe_pkg.sv ====
`default_nettype none

package mips_pipe_pkg;

  import mips_isa_pkg::*;

  // per-instruction control, produced in ID
  typedef struct packed {
    logic    reg_write;
    logic    reg_dst;    // rd instead of rt
    logic    alu_src;    // immediate operand
    logic    mem_write;
    logic    mem_to_reg; // load
    logic    branch;
    logic    branch_ne;  // bne, travels with the branch
    logic    sign_ext;
    logic    shift16;    // lui
    alu_op_e alu_op;
  } ctrl_t;

  // forwarding mux selects
  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_wb   = 2'b01,
    fwd_mem  = 2'b10
  } fwd_sel_e;

  // --------------------
  // pipeline registers
  // --------------------
  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc_plus4;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_write;
    logic      mem_to_reg;
    logic      branch_taken;
    word_t     branch_target;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    word_t     alu_result;
    word_t     load_data;
    reg_addr_t dest;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== mips_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  output word_t      pc,
  input  wire word_t instr,
  output word_t      mem_addr,
  output word_t      mem_wdata,
  output logic       mem_write,
  input  wire word_t mem_rdata
);

  word_t     pc_plus4;
  word_t     pc_next;
  word_t     if_instr;     // IF/ID
  word_t     if_pc_plus4;
  ctrl_t     dec_ctrl;
  ctrl_t     id_ctrl;
  reg_addr_t id_rs;
  reg_addr_t id_rt;
  reg_addr_t id_rd;
  word_t     id_imm;
  word_t     rf_rd1;
  word_t     rf_rd2;
  logic      stall;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;
  word_t     fwd_rs;
  word_t     fwd_rt;
  word_t     ex_imm;
  word_t     alu_b;
  word_t     alu_result;
  logic      alu_zero;
  word_t     wb_data;

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // --------------------
  // fetch
  // --------------------
  assign pc_plus4 = pc + pc_step;
  assign pc_next  = ex_mem.branch_taken ? ex_mem.branch_target : pc_plus4;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc       <= reset_pc;
      if_instr <= '0;  // decodes as nop
    end
    else if (!stall)
    begin
      pc       <= pc_next;
      if_instr <= instr;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      if_pc_plus4 <= pc_plus4;
  end

  // --------------------
  // decode
  // --------------------
  assign id_rs = if_instr[rs_lsb +: 5];
  assign id_rt = if_instr[rt_lsb +: 5];
  assign id_rd = if_instr[rd_lsb +: 5];

  main_decoder u_dec (.instr(if_instr), .ctrl(dec_ctrl));

  assign id_ctrl = stall ? '0 : dec_ctrl;  // bubble into EX
  assign id_imm  = dec_ctrl.sign_ext ?
                   {{(32-imm_width){if_instr[imm_width-1]}}, if_instr[imm_width-1:0]} :
                   {{(32-imm_width){1'b0}}, if_instr[imm_width-1:0]};

  reg_file u_rf (
    .clk(clk), .rst(rst),
    .we(mem_wb.reg_write), .wa(mem_wb.dest), .wd(wb_data),
    .ra1(id_rs), .ra2(id_rt), .rd1(rf_rd1), .rd2(rf_rd2)
  );

  hazard_unit u_hz (
    .clk(clk), .rst(rst),
    .ex_rs(id_ex.rs), .ex_rt(id_ex.rt),
    .ex_dest_mem(ex_mem.dest), .ex_dest_wb(mem_wb.dest),
    .id_rs(id_rs), .id_rt(id_rt),
    .mem_reg_write(ex_mem.reg_write), .wb_reg_write(mem_wb.reg_write),
    .ex_mem_to_reg(id_ex.ctrl.mem_to_reg),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
      id_ex.ctrl <= '0;
    else
      id_ex.ctrl <= id_ctrl;
    id_ex.pc_plus4 <= if_pc_plus4;
    id_ex.rs_data  <= rf_rd1;
    id_ex.rt_data  <= rf_rd2;
    id_ex.imm      <= id_imm;
    id_ex.rs       <= id_rs;
    id_ex.rt       <= id_rt;
    id_ex.rd       <= id_rd;
  end

  // --------------------
  // execute
  // --------------------
  assign fwd_rs = fwd_mux(fwd_a, id_ex.rs_data, ex_mem.alu_result, wb_data);
  assign fwd_rt = fwd_mux(fwd_b, id_ex.rt_data, ex_mem.alu_result, wb_data);
  assign ex_imm = id_ex.ctrl.shift16 ?
                  {id_ex.imm[imm_width-1:0], {imm_width{1'b0}}} : id_ex.imm;
  assign alu_b  = id_ex.ctrl.alu_src ? ex_imm : fwd_rt;

  alu u_alu (.a(fwd_rs), .b(alu_b), .op(id_ex.ctrl.alu_op), .result(alu_result),
             .zero(alu_zero));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ex_mem.reg_write    <= 1'b0;
      ex_mem.mem_write    <= 1'b0;
      ex_mem.mem_to_reg   <= 1'b0;
      ex_mem.branch_taken <= 1'b0;
    end
    else
    begin
      ex_mem.reg_write    <= id_ex.ctrl.reg_write;
      ex_mem.mem_write    <= id_ex.ctrl.mem_write;
      ex_mem.mem_to_reg   <= id_ex.ctrl.mem_to_reg;
      ex_mem.branch_taken <= id_ex.ctrl.branch &&
                             (id_ex.ctrl.branch_ne ? !alu_zero : alu_zero);
    end
    ex_mem.branch_target <= id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};
    ex_mem.alu_result    <= alu_result;
    ex_mem.store_data    <= fwd_rt;  // forwarded store value
    ex_mem.dest          <= id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
  end

  // --------------------
  // memory and writeback
  // --------------------
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_write = ex_mem.mem_write;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_wb.reg_write  <= 1'b0;
      mem_wb.mem_to_reg <= 1'b0;
    end
    else
    begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
    end
    mem_wb.alu_result <= ex_mem.alu_result;
    mem_wb.load_data  <= mem_rdata;
    mem_wb.dest       <= ex_mem.dest;
  end

  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

  // a stall here would drop the redirect
  a_branch_no_stall: assert property (@(posedge clk) disable iff (rst)
    !(ex_mem.branch_taken && stall))
    else $error("taken branch in MEM during load-use stall");

  a_mem_write_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(mem_write))
    else $error("mem_write unknown");

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import mips_isa_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            we,
  input  wire reg_addr_t wa,
  input  wire word_t     wd,
  input  wire reg_addr_t ra1,
  input  wire reg_addr_t ra2,
  output word_t          rd1,
  output word_t          rd2
);

  word_t regs [reg_count];

  // same-cycle write is seen by the reader
  function automatic word_t read_port(input reg_addr_t ra);
    if (we && (wa != '0) && (wa == ra))
      return wd;
    else
      return regs[ra];
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      regs[0] <= '0;  // r0 cleared here and never written
    else if (we && (wa != '0))
      regs[wa] <= wd;
  end

  always_comb
  begin
    rd1 = read_port(ra1);
    rd2 = read_port(ra2);
  end

  a_r0_zero: assert property (@(posedge clk) disable iff (rst)
    ((ra1 == '0) |-> (rd1 == '0)) and ((ra2 == '0) |-> (rd2 == '0)))
    else $error("register 0 read nonzero");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the MIPS pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module tb_mips -f build.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see $build_log"
  exit 1
fi

./obj_dir/Vtb_mips > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
  echo "simulator exited with an error status, see $sim_log"
fi

if grep -qx "Simulation finished: PASS" "$sim_log"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail, see $sim_log"
exit 1

// ==== tb_mips.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips
  import mips_isa_pkg::*;
();

  typedef struct packed {
    word_t addr;
    word_t data;
  } store_t;

  logic   clk = 1'b0;
  logic   rst;
  word_t  instr;
  word_t  mem_rdata;
  word_t  pc;
  word_t  mem_addr;
  word_t  mem_wdata;
  logic   mem_write;

  word_t  imem [64];
  word_t  dmem [64];
  store_t exp_stores [64];   // model's stores in program order
  bit     stall_at [64];     // word index where pc should hold once
  int     prog_len = 0;
  int     exp_count = 0;
  int     exp_holds = 0;
  int     store_count = 0;
  int     hold_count = 0;
  int     run_cycles = 0;
  logic   rst_q = 1'b0;
  word_t  prev_pc;
  logic   pc_held;
  store_t next_store;

  mips_pipeline dut0 (
    .clk(clk), .rst(rst), .pc(pc), .instr(instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_write(mem_write),
    .mem_rdata(mem_rdata)
  );

  always #2 clk = ~clk;

  // --------------------
  // helpers
  // --------------------
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic word_t rtype_word(input funct_e fn, input int rd, input int rs,
                                       input int rt);
    return {6'b0, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
  endfunction

  function automatic word_t itype_word(input opcode_e op, input int rt, input int rs,
                                       input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic word_t fetch_word(input word_t addr);
    if (addr[31:8] != '0)
      return '0;  // nop past the end of the image
    else
      return imem[addr[7:2]];
  endfunction

  task automatic append_instr(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic load_program();
    for (int i = 0; i < 64; i++)
      imem[i] = '0;
    // operands from the random data words
    append_instr(itype_word(op_lw, 1, 0, 16'h0000));
    append_instr(itype_word(op_lw, 2, 0, 16'h0004));
    append_instr(itype_word(op_lw, 3, 0, 16'h0008));
    append_instr(itype_word(op_lw, 4, 0, 16'h000c));
    append_instr(rtype_word(fn_add, 5, 1, 2));
    append_instr(rtype_word(fn_sub, 6, 3, 4));
    append_instr(rtype_word(fn_and, 7, 1, 3));
    append_instr(rtype_word(fn_or, 8, 2, 4));
    append_instr(rtype_word(fn_slt, 9, 1, 2));
    append_instr(itype_word(op_addi, 10, 3, 16'hff9c));  // -100
    append_instr(itype_word(op_ori, 11, 4, 16'h8a5c));
    for (int r = 5; r <= 11; r++)
      append_instr(itype_word(op_sw, r, 0, 16'(16'h0080 + 4 * (r - 5))));
    // dependent chain at distance 1, 2 and 3
    append_instr(rtype_word(fn_addu, 12, 1, 4));
    append_instr(rtype_word(fn_subu, 13, 12, 2));
    append_instr(rtype_word(fn_add, 14, 12, 13));
    append_instr(itype_word(op_sw, 14, 0, 16'h009c));
    append_instr(rtype_word(fn_or, 15, 13, 12));
    append_instr(itype_word(op_sw, 15, 0, 16'h00a0));
    append_instr(itype_word(op_lw, 16, 0, 16'h0010));  // load-use pair
    append_instr(rtype_word(fn_add, 17, 16, 5));
    append_instr(itype_word(op_sw, 17, 0, 16'h00a4));
    append_instr(itype_word(op_lui, 18, 0, 16'h1234));
    append_instr(itype_word(op_ori, 18, 18, 16'habcd));
    append_instr(itype_word(op_sw, 18, 0, 16'h00a8));
    // --------------------
    // branches with three slots each
    // --------------------
    append_instr(itype_word(op_beq, 1, 1, 16'd5));      // taken
    for (int r = 1; r <= 5; r++)
      append_instr(itype_word(op_sw, r, 0, 16'(16'h00ac + 4 * (r - 1))));
    append_instr(itype_word(op_beq, 2, 1, 16'd5));      // not taken
    for (int r = 6; r <= 9; r++)
      append_instr(itype_word(op_sw, r, 0, 16'(16'h00c0 + 4 * (r - 6))));
    append_instr(itype_word(op_bne, 4, 3, 16'd4));      // taken
    for (int r = 10; r <= 13; r++)
      append_instr(itype_word(op_sw, r, 0, 16'(16'h00d0 + 4 * (r - 10))));
    append_instr(itype_word(op_bne, 2, 2, 16'd3));      // not taken
    for (int r = 14; r <= 17; r++)
      append_instr(itype_word(op_sw, r, 0, 16'(16'h00e0 + 4 * (r - 14))));
  endtask

  // --------------------
  // reference model
  // --------------------
  task automatic run_model();
    word_t     regs [reg_count];
    word_t     data_copy [64];
    word_t     w;
    word_t     a;
    word_t     b;
    word_t     simm;
    word_t     res;
    word_t     addr;
    opcode_e   op;
    reg_addr_t dest;
    reg_addr_t load_rt;
    logic      load_valid;
    logic      wr;
    int        idx;
    int        next_idx;
    int        target;
    int        slots_left;
    int        steps;
    for (int i = 0; i < reg_count; i++)
      regs[i] = '0;
    for (int i = 0; i < 64; i++)
      data_copy[i] = dmem[i];
    idx        = 0;
    target     = 0;
    slots_left = 0;
    steps      = 0;
    load_valid = 1'b0;
    load_rt    = '0;
    while ((idx < prog_len) && (steps < 256))
    begin
      w    = imem[idx];
      op   = opcode_e'(w[31:26]);
      a    = regs[w[25:21]];
      b    = regs[w[20:16]];
      simm = {{16{w[15]}}, w[15:0]};
      dest = w[20:16];
      wr   = 1'b0;
      res  = '0;
      addr = a + simm;
      // reader right behind a load holds pc at the next fetch
      if (load_valid && ((w[25:21] == load_rt) || (w[20:16] == load_rt)))
      begin
        stall_at[idx + 1] = 1'b1;
        exp_holds++;
      end
      load_valid = (op == op_lw);
      load_rt    = w[20:16];
      next_idx   = idx + 1;
      if (slots_left > 0)
      begin
        slots_left--;
        if (slots_left == 0)
          next_idx = target;
      end
      case (op)
        op_rtype:
        begin
          wr   = 1'b1;
          dest = w[15:11];
          case (funct_e'(w[5:0]))
            fn_add, fn_addu: res = a + b;
            fn_sub, fn_subu: res = a - b;
            fn_and:          res = a & b;
            fn_or:           res = a | b;
            fn_slt:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         wr = 1'b0;
          endcase
        end
        op_addi, op_addiu:
        begin
          wr  = 1'b1;
          res = a + simm;
        end
        op_ori:
        begin
          wr  = 1'b1;
          res = a | {16'b0, w[15:0]};
        end
        op_lui:
        begin
          wr  = 1'b1;
          res = {w[15:0], 16'b0};
        end
        op_lw:
        begin
          wr  = 1'b1;
          res = data_copy[addr[7:2]];
        end
        op_sw:
        begin
          data_copy[addr[7:2]]  = b;
          exp_stores[exp_count] = {addr, b};
          exp_count++;
        end
        op_beq, op_bne:
        begin
          if ((a == b) == (op == op_beq))
          begin
            slots_left = 3;
            target     = idx + 1 + int'($signed(w[15:0]));
          end
        end
        default: ;
      endcase
      if (wr && (dest != '0))
        regs[dest] = res;
      idx = next_idx;
      steps++;
    end
  endtask

  task automatic wait_for_stores(input int limit);
    int waited;
    waited = 0;
    while ((store_count < exp_count) && (waited < limit))
    begin
      @(negedge clk);
      waited++;
    end
    if (store_count < exp_count)
      stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d stores seen",
                                  waited, store_count, exp_count));
  endtask

  // --------------------
  // memories and monitors
  // --------------------
  always @(negedge clk)
  begin
    instr     = fetch_word(pc);
    mem_rdata = dmem[mem_addr[7:2]];
  end

  always @(posedge clk)
  begin
    rst_q   <= rst;
    prev_pc <= pc;
    if (rst)
      run_cycles <= 0;
    else
      run_cycles <= run_cycles + 1;
    if (pc_held)
      hold_count <= hold_count + 1;
    if (!rst && mem_write)
    begin
      dmem[mem_addr[7:2]] = mem_wdata;
      store_count <= store_count + 1;
    end
  end

  assign pc_held    = (run_cycles >= 1) && (pc == prev_pc);
  assign next_store = exp_stores[store_count[5:0]];

  a_reset_pc: assert property (@(posedge clk) rst_q |-> (pc == reset_pc))
    else stop_with_failure($sformatf("CHECK FAILED: pc got %h expected %h", pc, reset_pc));

  a_reset_quiet: assert property (@(posedge clk) rst_q |-> !mem_write)
    else stop_with_failure($sformatf("CHECK FAILED: mem_write got %h expected 0", mem_write));

  a_store_addr: assert property (@(posedge clk) disable iff (rst)
    mem_write |-> (mem_addr == next_store.addr))
    else stop_with_failure($sformatf("CHECK FAILED: mem_addr got %h expected %h",
                                     mem_addr, next_store.addr));

  a_store_data: assert property (@(posedge clk) disable iff (rst)
    mem_write |-> (mem_wdata == next_store.data))
    else stop_with_failure($sformatf("CHECK FAILED: mem_wdata got %h expected %h",
                                     mem_wdata, next_store.data));

  a_hold_expected: assert property (@(posedge clk) disable iff (rst)
    pc_held |-> stall_at[pc[7:2]])
    else stop_with_failure($sformatf("pc held at %h with no load-use pair before it", pc));

  a_hold_single: assert property (@(posedge clk) disable iff (rst) pc_held |=> !pc_held)
    else stop_with_failure($sformatf("pc held at %h for more than one cycle", pc));

  initial
  begin
    rst       = 1'b1;
    instr     = '0;
    mem_rdata = '0;
    void'($urandom(32'hebfa));
    for (int i = 0; i < 64; i++)
      dmem[i] = $urandom;
    load_program();
    run_model();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait_for_stores(500);
    if (hold_count == exp_holds)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
      stop_with_failure($sformatf("CHECK FAILED: pc hold count got %h expected %h",
                                  hold_count, exp_holds));
  end

endmodule

`default_nettype wire
